// ==== include/bsr_settings.svh ====
`ifndef BSR_SETTINGS_SVH
`define BSR_SETTINGS_SVH

// ========================================
// Block geometry
// ========================================
`define BSR_BLOCK_SIZE 64   // Bytes in one 8x8 block
`define BSR_DATA_W     8    // INT8 element

// Counts 0..63 inside a block
`define BSR_BYTE_CNT_W 6

// ========================================
// Index widths
// ========================================
`define BSR_ROW_W      16   // Block-row number, row_ptr address
`define BSR_IDX_W      32   // Block index, row_ptr data, byte address
`define BSR_COL_W      16   // Block-column index

`endif

// ==== design/bsr_pkg.sv ====
`default_nettype none

package bsr_pkg;

    // ========================================
    // Scheduler states
    // ========================================
    typedef enum logic [3:0] {
        IDLE,         // Waiting for start
        ROW_PTR_LO,   // Address row_ptr[row]
        ROW_PTR_HI,   // Address row_ptr[row+1], start returns
        CHECK_EMPTY,  // End returns, compare with start
        COL_IDX,      // Address col_idx[block_idx]
        LOAD_INIT,    // Column returns, byte counter cleared
        LOAD,         // 64 byte reads
        LOAD_DRAIN,   // Last byte lands in buffer
        SEND,         // Block offered to the array
        WAIT_DONE,    // Array computing
        NEXT_BLOCK,   // Step to next block of the row
        NEXT_ROW,     // Step to next block row
        FINISH        // One-cycle done
    } sched_state_e;

endpackage

`default_nettype wire

// ==== design/bsr_sched_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module bsr_sched_fsm (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 start,
    input  wire logic                 systolic_ready,
    input  wire logic                 systolic_done,
    input  wire logic                 row_empty,       // From row tracker, valid in CHECK_EMPTY
    input  wire logic                 last_row,
    input  wire logic                 last_block,
    input  wire logic                 load_last,       // Byte 63 being read
    output bsr_pkg::sched_state_e     state,
    output logic                      systolic_valid,
    output logic                      busy,
    output logic                      done
);

    bsr_pkg::sched_state_e next_state;

    // ========================================
    // State register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= bsr_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ========================================
    // Next-state logic
    // ========================================
    always_comb begin
        next_state = state;  // Hold by default
        case (state)
            bsr_pkg::IDLE: begin
                if (start) next_state = bsr_pkg::ROW_PTR_LO;
            end
            bsr_pkg::ROW_PTR_LO:  next_state = bsr_pkg::ROW_PTR_HI;
            bsr_pkg::ROW_PTR_HI:  next_state = bsr_pkg::CHECK_EMPTY;
            bsr_pkg::CHECK_EMPTY: begin
                if (!row_empty)    next_state = bsr_pkg::COL_IDX;
                else if (last_row) next_state = bsr_pkg::FINISH;   // Empty tail row
                else               next_state = bsr_pkg::NEXT_ROW;
            end
            bsr_pkg::COL_IDX:     next_state = bsr_pkg::LOAD_INIT;
            bsr_pkg::LOAD_INIT:   next_state = bsr_pkg::LOAD;
            bsr_pkg::LOAD: begin
                if (load_last) next_state = bsr_pkg::LOAD_DRAIN;
            end
            bsr_pkg::LOAD_DRAIN:  next_state = bsr_pkg::SEND;
            bsr_pkg::SEND: begin
                if (systolic_ready) next_state = bsr_pkg::WAIT_DONE;  // Array took the block
            end
            bsr_pkg::WAIT_DONE: begin
                if (systolic_done) next_state = bsr_pkg::NEXT_BLOCK;
            end
            bsr_pkg::NEXT_BLOCK: begin
                // Flags still describe the block just finished
                if (!last_block)   next_state = bsr_pkg::COL_IDX;
                else if (last_row) next_state = bsr_pkg::FINISH;
                else               next_state = bsr_pkg::NEXT_ROW;
            end
            bsr_pkg::NEXT_ROW:    next_state = bsr_pkg::ROW_PTR_LO;
            bsr_pkg::FINISH:      next_state = bsr_pkg::IDLE;
            default:              next_state = bsr_pkg::IDLE;
        endcase
    end

    // ========================================
    // Status decode
    // ========================================
    assign systolic_valid = (state == bsr_pkg::SEND);
    assign busy = (state != bsr_pkg::IDLE) && (state != bsr_pkg::FINISH);
    assign done = (state == bsr_pkg::FINISH);  // Single cycle, FINISH always exits

    // Offered block may not be withdrawn before the array accepts it
    a_valid_held : assert property (@(posedge clk) disable iff (!rst_n)
        systolic_valid && !systolic_ready |=> systolic_valid);

    // State register stays within the encoded range
    a_state_legal : assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(state) && ($unsigned(state) <= $unsigned(bsr_pkg::FINISH)));

endmodule

`default_nettype wire

// ==== design/bsr_row_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "bsr_settings.svh"

module bsr_row_tracker (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire bsr_pkg::sched_state_e state,
    input  wire logic [`BSR_ROW_W-1:0] cfg_num_block_rows,  // Stable while busy
    input  wire logic [`BSR_IDX_W-1:0] row_ptr_rd_data,
    input  wire logic                  systolic_done,
    output logic                       row_ptr_rd_en,
    output logic [`BSR_ROW_W-1:0]      row_ptr_rd_addr,
    output logic                       col_idx_rd_en,
    output logic [`BSR_IDX_W-1:0]      col_idx_rd_addr,
    output logic [`BSR_IDX_W-1:0]      block_idx,
    output logic [`BSR_ROW_W-1:0]      block_row,
    output logic                       row_empty,
    output logic                       last_row,
    output logic                       last_block,
    output logic [`BSR_IDX_W-1:0]      blocks_processed
);

    logic [`BSR_IDX_W-1:0] block_start;  // row_ptr[block_row]
    logic [`BSR_IDX_W-1:0] block_end;    // row_ptr[block_row+1]

    // ========================================
    // Memory read ports
    // ========================================
    assign row_ptr_rd_en = (state == bsr_pkg::ROW_PTR_LO) || (state == bsr_pkg::ROW_PTR_HI);
    assign row_ptr_rd_addr = (state == bsr_pkg::ROW_PTR_HI) ? block_row + 1'b1 : block_row;

    assign col_idx_rd_en = (state == bsr_pkg::COL_IDX);
    assign col_idx_rd_addr = block_idx;  // Data back in LOAD_INIT

    // ========================================
    // Row and block registers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_row        <= '0;
            block_start      <= '0;
            block_end        <= '0;
            block_idx        <= '0;
            blocks_processed <= '0;
        end else begin
            case (state)
                bsr_pkg::ROW_PTR_LO: begin
                    // Row 0 is fetched once per run, so the count restarts here
                    if (block_row == '0) blocks_processed <= '0;
                end
                bsr_pkg::ROW_PTR_HI:  block_start <= row_ptr_rd_data;  // From LO read
                bsr_pkg::CHECK_EMPTY: begin
                    block_end <= row_ptr_rd_data;   // From HI read
                    block_idx <= block_start;       // First block of the row
                end
                bsr_pkg::WAIT_DONE: begin
                    if (systolic_done) blocks_processed <= blocks_processed + 1'b1;
                end
                bsr_pkg::NEXT_BLOCK:  block_idx <= block_idx + 1'b1;
                bsr_pkg::NEXT_ROW: begin
                    block_row   <= block_row + 1'b1;
                    block_start <= block_end;       // End of this row opens the next
                end
                bsr_pkg::FINISH:      block_row <= '0;  // Ready for the next start
                default: ;
            endcase
        end
    end

    // ========================================
    // Flags for the FSM
    // ========================================
    // Compared against the arriving end, not yet registered
    assign row_empty  = (state == bsr_pkg::CHECK_EMPTY) && (row_ptr_rd_data == block_start);
    assign last_row   = (block_row == cfg_num_block_rows - 1'b1);
    assign last_block = (block_idx + 1'b1 == block_end);

    // Row pointers must be non-decreasing
    a_ptr_monotonic : assert property (@(posedge clk) disable iff (!rst_n)
        (state == bsr_pkg::CHECK_EMPTY) |-> (row_ptr_rd_data >= block_start));

endmodule

`default_nettype wire

// ==== design/bsr_load_counter.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "bsr_settings.svh"

module bsr_load_counter (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire bsr_pkg::sched_state_e state,
    input  wire logic [`BSR_IDX_W-1:0] block_idx,
    output logic                       block_rd_en,
    output logic [`BSR_IDX_W-1:0]      block_rd_addr,
    output logic                       buf_wr_en,    // Delayed copy of block_rd_en
    output logic [`BSR_BYTE_CNT_W-1:0] buf_wr_sel,   // Byte slot for returning data
    output logic                       load_last
);

    logic [`BSR_BYTE_CNT_W-1:0] byte_cnt;

    // ========================================
    // Byte counter
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt  <= '0;
            buf_wr_en <= 1'b0;
        end else begin
            if (state == bsr_pkg::LOAD_INIT) byte_cnt <= '0;
            else if (state == bsr_pkg::LOAD) byte_cnt <= byte_cnt + 1'b1;  // Wraps after 63
            buf_wr_en <= block_rd_en;  // Read data valid one cycle later
        end
    end

    always_ff @(posedge clk) begin
        buf_wr_sel <= byte_cnt;  // Paired with buf_wr_en
    end

    // ========================================
    // Read port
    // ========================================
    assign block_rd_en = (state == bsr_pkg::LOAD);
    // Block j occupies bytes 64j .. 64j+63
    assign block_rd_addr = block_idx * `BSR_IDX_W'(`BSR_BLOCK_SIZE) + `BSR_IDX_W'(byte_cnt);
    assign load_last = block_rd_en &&
                       (byte_cnt == `BSR_BYTE_CNT_W'(`BSR_BLOCK_SIZE - 1));

    // Reads stop once the last byte is addressed
    a_rd_only_load : assert property (@(posedge clk) disable iff (!rst_n)
        load_last |=> !block_rd_en);

endmodule

`default_nettype wire

// ==== design/bsr_block_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "bsr_settings.svh"

module bsr_block_buffer (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire bsr_pkg::sched_state_e      state,
    input  wire logic [`BSR_COL_W-1:0]      col_idx_rd_data,
    input  wire logic [`BSR_DATA_W-1:0]     block_rd_data,
    input  wire logic                       buf_wr_en,
    input  wire logic [`BSR_BYTE_CNT_W-1:0] buf_wr_sel,
    output logic [`BSR_BLOCK_SIZE*`BSR_DATA_W-1:0] systolic_block,  // Byte k at bits 8k up
    output logic [`BSR_COL_W-1:0]           systolic_block_col
);

    logic [`BSR_DATA_W-1:0] buf_mem [`BSR_BLOCK_SIZE];

    // ========================================
    // Column register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            systolic_block_col <= '0;
        end else if (state == bsr_pkg::LOAD_INIT) begin
            systolic_block_col <= col_idx_rd_data;  // Answer to the COL_IDX read
        end
    end

    // ========================================
    // Byte storage
    // ========================================
    // Written only while loading, so the block is frozen during SEND
    always_ff @(posedge clk) begin
        if (buf_wr_en) buf_mem[buf_wr_sel] <= block_rd_data;
    end

    // Flatten for the array
    always_comb begin
        for (int k = 0; k < `BSR_BLOCK_SIZE; k++) begin
            systolic_block[k*`BSR_DATA_W +: `BSR_DATA_W] = buf_mem[k];
        end
    end

endmodule

`default_nettype wire

// ==== design/bsr_scheduler_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "bsr_settings.svh"

module bsr_scheduler_top (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       start,
    input  wire logic [`BSR_ROW_W-1:0]      cfg_num_block_rows,
    // Row pointer memory
    output logic                            row_ptr_rd_en,
    output logic [`BSR_ROW_W-1:0]           row_ptr_rd_addr,
    input  wire logic [`BSR_IDX_W-1:0]      row_ptr_rd_data,
    // Column index memory
    output logic                            col_idx_rd_en,
    output logic [`BSR_IDX_W-1:0]           col_idx_rd_addr,
    input  wire logic [`BSR_COL_W-1:0]      col_idx_rd_data,
    // Block byte memory
    output logic                            block_rd_en,
    output logic [`BSR_IDX_W-1:0]           block_rd_addr,
    input  wire logic [`BSR_DATA_W-1:0]     block_rd_data,
    // Systolic array
    output logic                            systolic_valid,
    output logic [`BSR_BLOCK_SIZE*`BSR_DATA_W-1:0] systolic_block,
    output logic [`BSR_ROW_W-1:0]           systolic_block_row,
    output logic [`BSR_COL_W-1:0]           systolic_block_col,
    input  wire logic                       systolic_ready,
    input  wire logic                       systolic_done,
    // Status
    output logic                            done,
    output logic                            busy,
    output logic [`BSR_IDX_W-1:0]           blocks_processed
);

    // ========================================
    // Internal nets
    // ========================================
    bsr_pkg::sched_state_e      state;
    logic                       row_empty;
    logic                       last_row;
    logic                       last_block;
    logic                       load_last;
    logic [`BSR_IDX_W-1:0]      block_idx;
    logic                       buf_wr_en;
    logic [`BSR_BYTE_CNT_W-1:0] buf_wr_sel;

    bsr_sched_fsm fsm_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .systolic_ready (systolic_ready),
        .systolic_done  (systolic_done),
        .row_empty      (row_empty),
        .last_row       (last_row),
        .last_block     (last_block),
        .load_last      (load_last),
        .state          (state),
        .systolic_valid (systolic_valid),
        .busy           (busy),
        .done           (done)
    );

    bsr_row_tracker row_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .state              (state),
        .cfg_num_block_rows (cfg_num_block_rows),
        .row_ptr_rd_data    (row_ptr_rd_data),
        .systolic_done      (systolic_done),
        .row_ptr_rd_en      (row_ptr_rd_en),
        .row_ptr_rd_addr    (row_ptr_rd_addr),
        .col_idx_rd_en      (col_idx_rd_en),
        .col_idx_rd_addr    (col_idx_rd_addr),
        .block_idx          (block_idx),
        .block_row          (systolic_block_row),  // Current row goes straight to the array
        .row_empty          (row_empty),
        .last_row           (last_row),
        .last_block         (last_block),
        .blocks_processed   (blocks_processed)
    );

    bsr_load_counter load_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .state         (state),
        .block_idx     (block_idx),
        .block_rd_en   (block_rd_en),
        .block_rd_addr (block_rd_addr),
        .buf_wr_en     (buf_wr_en),
        .buf_wr_sel    (buf_wr_sel),
        .load_last     (load_last)
    );

    bsr_block_buffer buf_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .state              (state),
        .col_idx_rd_data    (col_idx_rd_data),
        .block_rd_data      (block_rd_data),
        .buf_wr_en          (buf_wr_en),
        .buf_wr_sel         (buf_wr_sel),
        .systolic_block     (systolic_block),
        .systolic_block_col (systolic_block_col)
    );

endmodule

`default_nettype wire

// ==== verification/bsr_mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "bsr_settings.svh"

module bsr_mem_model (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   row_ptr_rd_en,
    input  wire logic [`BSR_ROW_W-1:0]  row_ptr_rd_addr,
    output logic [`BSR_IDX_W-1:0]       row_ptr_rd_data,
    input  wire logic                   col_idx_rd_en,
    input  wire logic [`BSR_IDX_W-1:0]  col_idx_rd_addr,
    output logic [`BSR_COL_W-1:0]       col_idx_rd_data,
    input  wire logic                   block_rd_en,
    input  wire logic [`BSR_IDX_W-1:0]  block_rd_addr,
    output logic [`BSR_DATA_W-1:0]      block_rd_data,
    input  wire logic                   systolic_valid,
    output logic                        systolic_ready,
    output logic                        systolic_done
);

    // Contents written by the testbench
    logic [`BSR_IDX_W-1:0]  row_ptr_mem [32];
    logic [`BSR_COL_W-1:0]  col_mem [32];
    logic [`BSR_DATA_W-1:0] block_mem [2048];  // 32 blocks of 64 bytes

    int   ready_stall = 0;  // Cycles of valid before ready rises
    int   done_delay  = 0;  // Extra cycles before the done pulse
    int   wait_cnt;
    int   done_cnt;
    logic done_pend;

    // ========================================
    // Read ports, data one cycle after enable
    // ========================================
    always @(posedge clk) begin
        if (row_ptr_rd_en) row_ptr_rd_data <= row_ptr_mem[row_ptr_rd_addr[4:0]];
        if (col_idx_rd_en) col_idx_rd_data <= col_mem[col_idx_rd_addr[4:0]];
        if (block_rd_en)   block_rd_data   <= block_mem[block_rd_addr[10:0]];
    end

    // ========================================
    // Systolic responder
    // ========================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            systolic_ready <= 1'b0;
            systolic_done  <= 1'b0;
            wait_cnt       <= 0;
            done_cnt       <= 0;
            done_pend      <= 1'b0;
        end else begin
            systolic_done <= 1'b0;  // Pulse by default
            if (done_pend) begin
                if (done_cnt == done_delay) begin
                    systolic_done <= 1'b1;
                    done_pend     <= 1'b0;
                end else begin
                    done_cnt <= done_cnt + 1;
                end
            end
            if (systolic_valid && systolic_ready) begin  // Block taken on this edge
                systolic_ready <= 1'b0;
                wait_cnt       <= 0;
                done_pend      <= 1'b1;
                done_cnt       <= 0;
            end else if (systolic_valid) begin
                if (wait_cnt == ready_stall) systolic_ready <= 1'b1;
                else wait_cnt <= wait_cnt + 1;       // Still stalling
            end else begin
                systolic_ready <= 1'b0;
                wait_cnt       <= 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_bsr_scheduler.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "bsr_settings.svh"

module tb_bsr_scheduler;

    // Six tests of at most 16 blocks near 110 cycles each, stalls included, with wide margin
    localparam int max_cycles = 20000;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   start;
    logic [`BSR_ROW_W-1:0]                  cfg_num_block_rows;
    logic                                   row_ptr_rd_en;
    logic [`BSR_ROW_W-1:0]                  row_ptr_rd_addr;
    logic [`BSR_IDX_W-1:0]                  row_ptr_rd_data;
    logic                                   col_idx_rd_en;
    logic [`BSR_IDX_W-1:0]                  col_idx_rd_addr;
    logic [`BSR_COL_W-1:0]                  col_idx_rd_data;
    logic                                   block_rd_en;
    logic [`BSR_IDX_W-1:0]                  block_rd_addr;
    logic [`BSR_DATA_W-1:0]                 block_rd_data;
    logic                                   systolic_valid;
    logic [`BSR_BLOCK_SIZE*`BSR_DATA_W-1:0] systolic_block;
    logic [`BSR_ROW_W-1:0]                  systolic_block_row;
    logic [`BSR_COL_W-1:0]                  systolic_block_col;
    logic                                   systolic_ready;
    logic                                   systolic_done;
    logic                                   done;
    logic                                   busy;
    logic [`BSR_IDX_W-1:0]                  blocks_processed;

    // Accepted blocks, in order
    logic [`BSR_ROW_W-1:0]                  log_row [$];
    logic [`BSR_COL_W-1:0]                  log_col [$];
    logic [`BSR_BLOCK_SIZE*`BSR_DATA_W-1:0] log_block [$];

    logic                                   held;      // Last edge saw valid without ready
    logic [`BSR_BLOCK_SIZE*`BSR_DATA_W-1:0] held_block;
    logic [`BSR_ROW_W-1:0]                  held_row;
    logic [`BSR_COL_W-1:0]                  held_col;
    logic [31:0]                            rng_state = 32'd69556;
    int row_cnt [16];                                  // Blocks per row of the next matrix
    int error_count = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int done_count  = 0;
    int cycle_cnt   = 0;

    bsr_scheduler_top dut_i (.*);
    bsr_mem_model mem_i (.*);

    always #4 clk = ~clk;  // 8 ns period

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // Runaway guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // ========================================
    // Monitor of the systolic port
    // ========================================
    always @(posedge clk) begin
        if (done) done_count++;
        if (held) begin  // Offered block must stay put until taken
            if (!systolic_valid) report_error("systolic_valid dropped before ready");
            else if (systolic_block != held_block || systolic_block_col != held_col ||
                     systolic_block_row != held_row)
                report_error("offered block changed while waiting for ready");
        end
        if (systolic_valid && systolic_ready) begin
            log_row.push_back(systolic_block_row);
            log_col.push_back(systolic_block_col);
            log_block.push_back(systolic_block);
        end
        held       = systolic_valid && !systolic_ready;
        held_block = systolic_block;
        held_row   = systolic_block_row;
        held_col   = systolic_block_col;
    end

    // Row pointers from row_cnt, then random columns and bytes
    task automatic build_matrix(input int nrows);
        int i;
        int j;
        int k;
        logic [31:0] r;
        mem_i.row_ptr_mem[0] = '0;
        for (i = 0; i < nrows; i++)
            mem_i.row_ptr_mem[i+1] = mem_i.row_ptr_mem[i] + row_cnt[i];
        for (j = 0; j < mem_i.row_ptr_mem[nrows]; j++) begin
            r = next_rand();
            mem_i.col_mem[j] = r[15:0];
            for (k = 0; k < `BSR_BLOCK_SIZE; k++) begin
                r = next_rand();
                mem_i.block_mem[`BSR_BLOCK_SIZE*j+k] = r[7:0];
            end
        end
    endtask

    // Expected order is row by row, blocks row_ptr[i] .. row_ptr[i+1]-1
    task automatic compare_blocks(input int nrows);
        int i;
        int j;
        int k;
        int pos;
        logic [`BSR_BLOCK_SIZE*`BSR_DATA_W-1:0] exp_block;
        pos = 0;
        for (i = 0; i < nrows; i++) begin
            for (j = mem_i.row_ptr_mem[i]; j < mem_i.row_ptr_mem[i+1]; j++) begin
                for (k = 0; k < `BSR_BLOCK_SIZE; k++)
                    exp_block[k*`BSR_DATA_W +: `BSR_DATA_W] =
                        mem_i.block_mem[`BSR_BLOCK_SIZE*j+k];
                if (pos >= log_row.size())
                    report_error($sformatf("block %0d of row %0d never presented", j, i));
                else begin
                    if (log_row[pos] != i)
                        report_error($sformatf("block %0d row %0d, expected %0d",
                                               j, log_row[pos], i));
                    if (log_col[pos] != mem_i.col_mem[j])
                        report_error($sformatf("block %0d column %0h, expected %0h",
                                               j, log_col[pos], mem_i.col_mem[j]));
                    if (log_block[pos] != exp_block)
                        report_error($sformatf("block %0d payload differs", j));
                end
                pos++;
            end
        end
        if (log_row.size() != pos)
            report_error($sformatf("%0d blocks presented, expected %0d", log_row.size(), pos));
        if (blocks_processed != pos)
            report_error($sformatf("blocks_processed %0d, expected %0d", blocks_processed, pos));
    endtask

    task automatic run_test(input string name, input int nrows, input int stall,
                            input int delay);
        int errs_before;
        errs_before = error_count;
        build_matrix(nrows);
        mem_i.ready_stall  = stall;
        mem_i.done_delay   = delay;
        cfg_num_block_rows = nrows;
        log_row.delete();
        log_col.delete();
        log_block.delete();
        done_count = 0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (!busy) report_error("busy not raised after start");
        while (done_count == 0) @(negedge clk);
        repeat (3) @(negedge clk);
        if (done_count != 1) report_error($sformatf("done pulsed %0d times", done_count));
        if (busy) report_error("busy still high after done");
        compare_blocks(nrows);
        if (error_count == errs_before) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        cfg_num_block_rows = '0;
        held = 1'b0;
        repeat (4) @(negedge clk);
        if (busy || done || systolic_valid || row_ptr_rd_en || col_idx_rd_en || block_rd_en ||
            dut_i.fsm_i.state != bsr_pkg::IDLE)
            report_error("outputs not idle during reset");
        rst_n = 1'b1;
        @(negedge clk);

        row_cnt[0] = 3;
        run_test("single row, three blocks", 1, 0, 0);

        row_cnt = '{0, 2, 0, 0, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        run_test("empty rows skipped", 5, 0, 0);

        row_cnt[0] = 2;
        row_cnt[1] = 2;
        run_test("block payload", 2, 0, 0);

        row_cnt[0] = 2;
        run_test("back-pressure", 1, 10, 15);

        row_cnt = '{default: 0};
        run_test("all-empty matrix", 3, 0, 0);

        for (int i = 0; i < 8; i++) row_cnt[i] = int'(next_rand() % 3);
        run_test("random sparse matrix", 8, 2, 3);

        $display("Tests: %0d passed, %0d failed, %0d errors", pass_count, fail_count,
                 error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
design/bsr_pkg.sv
design/bsr_sched_fsm.sv
design/bsr_row_tracker.sv
design/bsr_load_counter.sv
design/bsr_block_buffer.sv
design/bsr_scheduler_top.sv
verification/bsr_mem_model.sv
verification/tb_bsr_scheduler.sv

// ==== Bender.yml ====
package:
  name: bsr_scheduler

sources:
  - include_dirs:
      - include
    files:
      - design/bsr_pkg.sv
      - design/bsr_sched_fsm.sv
      - design/bsr_row_tracker.sv
      - design/bsr_load_counter.sv
      - design/bsr_block_buffer.sv
      - design/bsr_scheduler_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/bsr_mem_model.sv
      - verification/tb_bsr_scheduler.sv
